// File: Makefile
TOP = core_pool_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TESTS PASSED$$'

clean:
	rm -rf obj_dir

// File: common/job_pkg.sv
package job_pkg;

   localparam int JOBQ_DEPTH    = 4;
   localparam int JOBQ_AW       = $clog2(JOBQ_DEPTH);
   localparam int GRANT_HOLDOFF = 2;            // Cycles until the next head is valid.

   typedef logic [7:0]         job_id_t;
   typedef logic [7:0]         opcode_t;
   typedef logic [JOBQ_AW-1:0] jobq_ptr_t;
   typedef logic [JOBQ_AW:0]   jobq_cnt_t;

   typedef struct packed {
      job_id_t tag;
      opcode_t opcode;
   } job_t;

   typedef struct packed {
      job_t               job;
      pool_pkg::core_id_t core;
   } grant_t;

   typedef logic [1:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   localparam reg_addr_t REG_CTRL  = 2'd0;
   localparam reg_addr_t REG_LIMIT = 2'd1;
   localparam reg_addr_t REG_FREE  = 2'd2;
   localparam reg_addr_t REG_ERR   = 2'd3;

endpackage

// File: common/pool_pkg.sv
package pool_pkg;

   localparam int CORES = 4;
   localparam int ID_W  = $clog2(CORES);
   localparam int PTR_W = ID_W + 1;            // Extra bit tells full from empty.
   localparam int CNT_W = $clog2(CORES + 1);

   // Core identifier as handed out to a job.
   typedef logic [ID_W-1:0] core_id_t;

   // Free list pointer, wraps at twice the core count.
   typedef logic [PTR_W-1:0] pool_ptr_t;

   // Free or busy core count, 0 to CORES.
   typedef logic [CNT_W-1:0] count_t;

   typedef enum logic [1:0] {
      RESET_WAIT,
      FILL,
      RUN
   } pool_state_t;

endpackage

// File: compile.f
+incdir+tb
common/pool_pkg.sv
common/job_pkg.sv
verilog/simple_dualportram.sv
core_manager/core_manager.sv
core_manager/pool_regs.sv
verilog/job_dispatcher.sv
verilog/core_pool_top.sv
tb/core_pool_tb.sv

// File: core_manager/core_manager.sv
`timescale 1ns/1ns

module core_manager (
   input  logic               clk,
   input  logic               reset,
   input  logic               core_request,
   input  logic               core_release,
   input  pool_pkg::core_id_t released_core_id,
   output logic               init_busy,
   output logic               core_valid,
   output pool_pkg::core_id_t core_id,
   output pool_pkg::count_t   free_count,
   output logic               underflow
);
   import pool_pkg::*;

   pool_state_t state;
   count_t      fill_cnt;
   pool_ptr_t   rd_ptr;
   pool_ptr_t   wr_ptr;
   core_id_t    mem_din;
   logic        mem_we;
   logic        empty;
   logic        pop;

   assign empty     = (rd_ptr == wr_ptr);
   assign pop       = (state == RUN) && core_request && !empty;
   assign init_busy = (state != RUN);

   always_comb begin
      mem_din = released_core_id;
      case (state)
         FILL: begin
            mem_we  = (fill_cnt != count_t'(CORES));
            mem_din = core_id_t'(fill_cnt);     // Initial list is 0 to CORES-1.
         end
         RUN:     mem_we = core_release;
         default: mem_we = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= RESET_WAIT;
         fill_cnt   <= '0;
         rd_ptr     <= '0;
         wr_ptr     <= '0;
         core_valid <= 1'b0;
         free_count <= '0;
         underflow  <= 1'b0;
      end else begin
         underflow <= 1'b0;
         case (state)
            RESET_WAIT: begin
               fill_cnt <= '0;
               state    <= FILL;
            end
            FILL: begin
               if (fill_cnt == count_t'(CORES)) begin
                  state <= RUN;
               end else begin
                  fill_cnt <= fill_cnt + 1'b1;
               end
            end
            RUN: begin
               if (pop) begin
                  rd_ptr <= rd_ptr + 1'b1;
               end
               underflow <= core_request && empty;
            end
            default: state <= RESET_WAIT;
         endcase
         if (mem_we) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // Valid lines up with the RAM read of the current rd_ptr.
         core_valid <= (state == RUN) && !empty;
         free_count <= count_t'(wr_ptr - rd_ptr);
      end
   end

   simple_dualportram u_ram (
      .clk      (clk),
      .reset    (reset),
      .raddress (rd_ptr),
      .waddress (wr_ptr),
      .din      (mem_din),
      .we       (mem_we),
      .dout     (core_id)
   );

   a_free_max: assert property (
      @(posedge clk) disable iff (reset)
      free_count <= count_t'(CORES)
   ) else $error("free count above core count");

   a_release_not_full: assert property (
      @(posedge clk) disable iff (reset)
      core_release |-> (pool_ptr_t'(wr_ptr - rd_ptr) != pool_ptr_t'(CORES))
   ) else $error("release into a full free list");

endmodule

// File: core_manager/pool_regs.sv
`timescale 1ns/1ns

module pool_regs (
   input  logic               clk,
   input  logic               reset,
   input  logic               cfg_we,
   input  job_pkg::reg_addr_t cfg_addr,
   input  job_pkg::reg_data_t cfg_wdata,
   input  pool_pkg::count_t   free_count,
   input  logic               bad_release,
   input  logic               underflow,
   output job_pkg::reg_data_t cfg_rdata,
   output logic               enable,
   output pool_pkg::count_t   busy_limit
);
   import pool_pkg::*;
   import job_pkg::*;

   logic [1:0] err_flags;
   logic [1:0] err_clear;
   logic [1:0] err_set;

   assign err_clear = (cfg_we && cfg_addr == REG_ERR) ? cfg_wdata[1:0] : 2'b00;
   assign err_set   = {underflow, bad_release};

   always_ff @(posedge clk) begin
      if (reset) begin
         enable     <= 1'b0;
         busy_limit <= count_t'(CORES);
         err_flags  <= 2'b00;
      end else begin
         if (cfg_we && cfg_addr == REG_CTRL) begin
            enable <= cfg_wdata[0];
         end
         if (cfg_we && cfg_addr == REG_LIMIT) begin
            if (cfg_wdata > reg_data_t'(CORES)) begin
               busy_limit <= count_t'(CORES);     // Clamp.
            end else begin
               busy_limit <= count_t'(cfg_wdata);
            end
         end
         // A new event wins over a clear in the same cycle.
         err_flags <= (err_flags & ~err_clear) | err_set;
      end
   end

   always_comb begin
      case (cfg_addr)
         REG_CTRL:  cfg_rdata = {7'd0, enable};
         REG_LIMIT: cfg_rdata = reg_data_t'(busy_limit);
         REG_FREE:  cfg_rdata = reg_data_t'(free_count);
         REG_ERR:   cfg_rdata = {6'd0, err_flags};
         default:   cfg_rdata = '0;
      endcase
   end

endmodule

// File: tb/pool_model.svh
`ifndef POOL_MODEL_SVH
`define POOL_MODEL_SVH

// Reference model of the pool. Included inside the testbench module.
core_id_t         free_q[$];                   // Free list in hand-out order.
job_t             job_q[$];
logic [CORES-1:0] busy_set;
logic             pend_valid;                  // Grant seen and not yet committed.
core_id_t         pend_core;
logic [1:0]       err_shadow;
logic             enable_shadow;
int               limit_shadow;
int               grant_count;

function automatic void reset_model();
   free_q.delete();
   job_q.delete();
   for (int i = 0; i < CORES; i++) begin
      free_q.push_back(core_id_t'(i));
   end
   busy_set      = '0;
   pend_valid    = 1'b0;
   pend_core     = '0;
   err_shadow    = 2'b00;
   enable_shadow = 1'b0;
   limit_shadow  = CORES;
   grant_count   = 0;
endfunction

function automatic void commit_grant();
   if (pend_valid) begin
      busy_set[pend_core] = 1'b1;
      pend_valid          = 1'b0;
   end
endfunction

function automatic void mark_release(core_id_t c);
   if (busy_set[c]) begin
      busy_set[c] = 1'b0;
      free_q.push_back(c);
   end else begin
      err_shadow[0] = 1'b1;                      // Release of an idle core.
   end
endfunction

function automatic void write_shadow(reg_addr_t a, reg_data_t d);
   case (a)
      REG_CTRL:  enable_shadow = d[0];
      REG_LIMIT: limit_shadow  = (d > CORES) ? CORES : int'(d);
      REG_ERR:   err_shadow    = err_shadow & ~d[1:0];
      default:   ;
   endcase
endfunction

function automatic reg_data_t expected_read(reg_addr_t a);
   case (a)
      REG_CTRL:  return reg_data_t'(enable_shadow);
      REG_LIMIT: return reg_data_t'(limit_shadow);
      REG_FREE:  return reg_data_t'(free_q.size());
      default:   return reg_data_t'(err_shadow);
   endcase
endfunction

function automatic int busy_count();
   return $countones(busy_set) + int'(pend_valid);
endfunction

function automatic core_id_t find_core(logic want_busy);
   for (int i = 0; i < CORES; i++) begin
      if (busy_set[i] == want_busy) begin
         return core_id_t'(i);
      end
   end
   return '0;
endfunction

`endif

// File: tb/core_pool_tb.sv
`timescale 1ns/1ns

module core_pool_tb;
   import pool_pkg::*;
   import job_pkg::*;

   logic      clk;
   logic      reset;
   logic      job_strobe;
   job_t      job;
   logic      job_ready;
   logic      grant_strobe;
   grant_t    grant;
   logic      done_strobe;
   core_id_t  done_core;
   logic      cfg_we;
   reg_addr_t cfg_addr;
   reg_data_t cfg_wdata;
   reg_data_t cfg_rdata;
   logic      init_busy;
   integer    seed;

   `include "pool_model.svh"

   core_pool_top u_core_pool_top (
      .clk          (clk),
      .reset        (reset),
      .job_strobe   (job_strobe),
      .job          (job),
      .job_ready    (job_ready),
      .grant_strobe (grant_strobe),
      .grant        (grant),
      .done_strobe  (done_strobe),
      .done_core    (done_core),
      .cfg_we       (cfg_we),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata),
      .init_busy    (init_busy)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_run(string why);
      $display("%s", why);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check(string name, int expected, int actual);
      if (expected != actual) begin
         fail_run($sformatf("** Error: %s expected %0d actual %0d", name, expected, actual));
      end
   endtask

   // One clock. Strobes drop and the model takes the grant of this cycle.
   task automatic tick();
      @(posedge clk);
      #1;
      commit_grant();
      job_strobe  = 1'b0;
      done_strobe = 1'b0;
      cfg_we      = 1'b0;
      check("job_ready", job_q.size() != JOBQ_DEPTH, job_ready);
      if (grant_strobe) begin
         if (job_q.size() == 0 || free_q.size() == 0) begin
            fail_run("grant issued with no job queued or no core free");
         end else begin
            check("grant enable", 1, enable_shadow);
            check("grant under limit", 1, $countones(busy_set) < limit_shadow);
            check("grant job", int'(job_q[0]), int'(grant.job));
            check("grant core", free_q[0], grant.core);
            void'(job_q.pop_front());
            void'(free_q.pop_front());
            pend_valid = 1'b1;
            pend_core  = grant.core;
            grant_count++;
         end
      end
   endtask

   task automatic idle(int n);
      repeat (n) tick();
   endtask

   function automatic job_t random_job();
      logic [31:0] r;
      r = $random(seed);
      return r[15:0];
   endfunction

   task automatic drive_job(job_t j);
      job_strobe = 1'b1;
      job        = j;
      if (job_ready) begin
         job_q.push_back(j);                     // Dropped while the queue is full.
      end
   endtask

   task automatic send_job(job_t j);
      drive_job(j);
      tick();
   endtask

   task automatic drive_release(core_id_t c);
      done_strobe = 1'b1;
      done_core   = c;
      mark_release(c);
   endtask

   task automatic release_core(core_id_t c);
      drive_release(c);
      tick();
   endtask

   // Stride 3 walks all cores in a shuffled order.
   task automatic release_all();
      int       start;
      core_id_t c;
      start = $random(seed) & 3;
      for (int i = 0; i < CORES; i++) begin
         c = core_id_t'(start + 3 * i);
         if (busy_set[c]) begin
            release_core(c);
         end
      end
   endtask

   task automatic write_reg(reg_addr_t a, reg_data_t d);
      cfg_we    = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      write_shadow(a, d);
      tick();
   endtask

   task automatic check_reg(string name, reg_addr_t a);
      cfg_addr = a;
      tick();
      check(name, expected_read(a), cfg_rdata);
   endtask

   task automatic wait_grants(int target, int max_cycles);
      int n;
      n = 0;
      while (grant_count < target && n < max_cycles) begin
         tick();
         n++;
      end
      if (grant_count < target) begin
         fail_run("timeout waiting for a grant");
      end
   endtask

   task automatic settle();
      int quiet;
      int n;
      quiet = 0;
      n     = 0;
      while (quiet < 8 && n < 200) begin
         tick();
         quiet = grant_strobe ? 0 : quiet + 1;
         n++;
      end
      if (quiet < 8) begin
         fail_run("timeout waiting for the pool to go quiet");
      end
   endtask

   initial begin
      int          cycles;
      int          base;
      int          free_before;
      logic [31:0] r;
      seed        = 83073;
      reset       = 1'b1;
      job_strobe  = 1'b0;
      job         = '0;
      done_strobe = 1'b0;
      done_core   = '0;
      cfg_we      = 1'b0;
      cfg_addr    = REG_CTRL;
      cfg_wdata   = '0;
      reset_model();
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      check("init_busy after reset", 1, init_busy);
      cycles = 0;
      while (init_busy && cycles < 20) begin
         tick();
         cycles++;
      end
      check("init cycles", CORES + 2, cycles);
      check_reg("init free", REG_FREE);
      check_reg("init ctrl", REG_CTRL);
      check_reg("init limit", REG_LIMIT);

      // Grants follow arrival order and take cores from the free list head.
      write_reg(REG_CTRL, 8'h01);
      for (int i = 0; i < 4; i++) send_job(random_job());
      wait_grants(4, 60);
      idle(3);
      release_all();
      for (int i = 0; i < 4; i++) send_job(random_job());
      wait_grants(8, 60);
      idle(3);

      release_all();
      settle();
      write_reg(REG_LIMIT, 8'd2);
      check_reg("limit two", REG_LIMIT);
      for (int i = 0; i < 4; i++) send_job(random_job());
      wait_grants(10, 60);
      base = grant_count;
      idle(20);
      check("grants at limit", base, grant_count);
      release_core(find_core(1'b1));
      wait_grants(11, 40);
      idle(3);
      release_core(find_core(1'b1));
      wait_grants(12, 40);
      idle(3);

      write_reg(REG_CTRL, 8'h00);
      write_reg(REG_LIMIT, 8'd7);
      check_reg("limit clamp", REG_LIMIT);
      release_all();
      settle();

      // Queue fills while grants are disabled.
      for (int i = 0; i < 4; i++) begin
         check("ready before full", 1, job_ready);
         send_job(random_job());
      end
      check("ready when full", 0, job_ready);
      base = grant_count;
      idle(20);
      check("grants while disabled", base, grant_count);
      send_job('{tag: 8'hee, opcode: 8'h5a});
      write_reg(REG_CTRL, 8'h01);
      wait_grants(base + 4, 60);
      settle();

      release_core(find_core(1'b1));
      settle();
      free_before = free_q.size();
      check_reg("free before bad release", REG_FREE);
      release_core(find_core(1'b0));
      idle(3);
      check_reg("err after bad release", REG_ERR);
      check("err bit 0 set", 1, cfg_rdata[0]);
      check_reg("free after bad release", REG_FREE);
      check("free unchanged", free_before, cfg_rdata);
      write_reg(REG_ERR, 8'h01);
      check_reg("err cleared", REG_ERR);
      check("err bit 0 clear", 0, cfg_rdata[0]);

      for (cycles = 0; cycles < 2000; cycles++) begin
         r = $random(seed);
         if (r[2:0] < 3'd3) begin
            drive_job(random_job());
         end
         if (r[5:4] == 2'd0 && busy_set[r[9:8]]) begin
            drive_release(core_id_t'(r[9:8]));
         end
         tick();
      end
      settle();
      check_reg("final free", REG_FREE);
      check("final free vs busy", CORES - busy_count(), cfg_rdata);
      check_reg("final err", REG_ERR);

      $display("TESTS PASSED");
      $finish;
   end

endmodule

// File: verilog/core_pool_top.sv
`timescale 1ns/1ns

module core_pool_top (
   input  logic               clk,
   input  logic               reset,
   input  logic               job_strobe,
   input  job_pkg::job_t      job,
   output logic               job_ready,
   output logic               grant_strobe,
   output job_pkg::grant_t    grant,
   input  logic               done_strobe,
   input  pool_pkg::core_id_t done_core,
   input  logic               cfg_we,
   input  job_pkg::reg_addr_t cfg_addr,
   input  job_pkg::reg_data_t cfg_wdata,
   output job_pkg::reg_data_t cfg_rdata,
   output logic               init_busy
);
   import pool_pkg::*;

   logic     core_request;
   logic     core_release;
   core_id_t released_core_id;
   logic     core_valid;
   core_id_t core_id;
   count_t   free_count;
   logic     underflow;
   logic     enable;
   count_t   busy_limit;
   logic     bad_release;

   core_manager u_core_manager (
      .clk              (clk),
      .reset            (reset),
      .core_request     (core_request),
      .core_release     (core_release),
      .released_core_id (released_core_id),
      .init_busy        (init_busy),
      .core_valid       (core_valid),
      .core_id          (core_id),
      .free_count       (free_count),
      .underflow        (underflow)
   );

   pool_regs u_pool_regs (
      .clk         (clk),
      .reset       (reset),
      .cfg_we      (cfg_we),
      .cfg_addr    (cfg_addr),
      .cfg_wdata   (cfg_wdata),
      .free_count  (free_count),
      .bad_release (bad_release),
      .underflow   (underflow),
      .cfg_rdata   (cfg_rdata),
      .enable      (enable),
      .busy_limit  (busy_limit)
   );

   job_dispatcher u_job_dispatcher (
      .clk              (clk),
      .reset            (reset),
      .job_strobe       (job_strobe),
      .job              (job),
      .done_strobe      (done_strobe),
      .done_core        (done_core),
      .enable           (enable),
      .busy_limit       (busy_limit),
      .core_valid       (core_valid),
      .core_id          (core_id),
      .job_ready        (job_ready),
      .grant_strobe     (grant_strobe),
      .grant            (grant),
      .core_request     (core_request),
      .core_release     (core_release),
      .released_core_id (released_core_id),
      .bad_release      (bad_release)
   );

endmodule

// File: verilog/job_dispatcher.sv
`timescale 1ns/1ns

module job_dispatcher (
   input  logic               clk,
   input  logic               reset,
   input  logic               job_strobe,
   input  job_pkg::job_t      job,
   input  logic               done_strobe,
   input  pool_pkg::core_id_t done_core,
   input  logic               enable,
   input  pool_pkg::count_t   busy_limit,
   input  logic               core_valid,
   input  pool_pkg::core_id_t core_id,
   output logic               job_ready,
   output logic               grant_strobe,
   output job_pkg::grant_t    grant,
   output logic               core_request,
   output logic               core_release,
   output pool_pkg::core_id_t released_core_id,
   output logic               bad_release
);
   import pool_pkg::*;
   import job_pkg::*;

   job_t             jobq [JOBQ_DEPTH];
   jobq_ptr_t        q_wr;
   jobq_ptr_t        q_rd;
   jobq_cnt_t        q_cnt;
   logic [CORES-1:0] busy;
   count_t           busy_cnt;
   logic [1:0]       holdoff;
   logic             push;
   logic             go;
   logic             rel_ok;

   assign job_ready = (q_cnt != jobq_cnt_t'(JOBQ_DEPTH));
   assign push      = job_strobe && job_ready;
   assign rel_ok    = done_strobe && busy[done_core];

   // Head core must be valid and settled after the last pop.
   assign go = (q_cnt != '0) && enable && core_valid &&
               (busy_cnt < busy_limit) && (holdoff == '0);

   assign grant_strobe = go;
   assign core_request = go;
   assign grant.job    = jobq[q_rd];
   assign grant.core   = core_id;

   always_ff @(posedge clk) begin
      if (push) begin
         jobq[q_wr] <= job;
      end
      if (rel_ok) begin
         released_core_id <= done_core;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         q_wr         <= '0;
         q_rd         <= '0;
         q_cnt        <= '0;
         busy         <= '0;
         busy_cnt     <= '0;
         holdoff      <= '0;
         core_release <= 1'b0;
         bad_release  <= 1'b0;
      end else begin
         if (push) begin
            q_wr <= q_wr + 1'b1;
         end
         if (go) begin
            q_rd <= q_rd + 1'b1;
         end
         q_cnt <= q_cnt + jobq_cnt_t'(push) - jobq_cnt_t'(go);

         if (go) begin
            busy[core_id] <= 1'b1;
         end
         if (rel_ok) begin
            busy[done_core] <= 1'b0;             // Never the core granted now.
         end
         busy_cnt <= busy_cnt + count_t'(go) - count_t'(rel_ok);

         if (go) begin
            holdoff <= 2'(GRANT_HOLDOFF);
         end else if (holdoff != '0) begin
            holdoff <= holdoff - 1'b1;
         end

         core_release <= rel_ok;
         bad_release  <= done_strobe && !rel_ok;
      end
   end

   a_grant_idle_core: assert property (
      @(posedge clk) disable iff (reset)
      grant_strobe |-> !busy[core_id]
   ) else $error("grant names a busy core");

endmodule

// File: verilog/simple_dualportram.sv
`timescale 1ns/1ns

module simple_dualportram (
   input  logic                clk,
   input  logic                reset,
   input  pool_pkg::pool_ptr_t raddress,
   input  pool_pkg::pool_ptr_t waddress,
   input  pool_pkg::core_id_t  din,
   input  logic                we,
   output pool_pkg::core_id_t  dout
);
   import pool_pkg::*;

   core_id_t mem [2**PTR_W];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddress] <= din;
      end
      dout <= mem[raddress];                    // Old data on a same-address write.
   end

   a_waddr_known: assert property (
      @(posedge clk) disable iff (reset)
      we |-> !$isunknown(waddress)
   ) else $error("RAM write with unknown address");

endmodule
